// ==== flist.f ====
design/cp0_pkg.sv
design/cp0_timer.sv
design/cp0_regs.sv
design/cp0_read_fwd.sv
design/cp0_exc_arbiter.sv
design/cp0_top.sv
verification/cp0_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cp0 testbench with Verilator and run it, the exit status tells pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module cp0_tb -o cp0_sim \
    && ./obj_dir/cp0_sim \
    || exit 1

// ==== verification/cp0_tb.sv ====
`timescale 1ns/1ps

module cp0_tb
    import cp0_pkg::*;
();

    localparam word_t PRID_CFG       = 32'h0048_0102;
    localparam word_t EXC_VECTOR_CFG = 32'hbfc0_0380;
    localparam int    CLK_PERIOD     = 40;
    localparam int    RESET_CYCLES   = 16;
    localparam int    PLANNED_CYCLES = 1500;
    localparam int    WATCHDOG_CYCLES = 2 * PLANNED_CYCLES;

    logic       clk;
    logic       rst_n_i;
    cp0_wr_t    wb_wr;
    cp0_wr_t    mem_wr;
    cp0_addr_e  raddr;
    logic [5:0] int_lines;
    mem_exc_t   mem_exc;
    word_t      rdata;
    word_t      status_v;
    word_t      cause_v;
    word_t      exc_target;
    logic       timer_int;
    logic       flush;
    exc_type_e  exc_type;

    string test_name;
    word_t rng_state;
    int    timer_cycles;
    int    int_cycles;
    int    flush_cycles;

    // shadow state
    word_t m_status;
    word_t m_cause;
    word_t m_epc;
    word_t m_compare;
    word_t m_count;
    logic  m_tint;

    word_t     exp_status;
    word_t     exp_cause;
    word_t     exp_rdata;
    word_t     stored;
    word_t     exp_target;
    exc_type_e exp_exc;
    logic      exp_flush;
    logic      int_taken;

    cp0_top #(
        .PRID_VALUE (PRID_CFG),
        .EXC_VECTOR (EXC_VECTOR_CFG)
    ) dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wb_wr_i      (wb_wr),
        .mem_wr_i     (mem_wr),
        .raddr_i      (raddr),
        .int_i        (int_lines),
        .mem_exc_i    (mem_exc),
        .rdata_o      (rdata),
        .status_o     (status_v),
        .cause_o      (cause_v),
        .timer_int_o  (timer_int),
        .flush_o      (flush),
        .exc_type_o   (exc_type),
        .exc_target_o (exc_target)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t xorshift32(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic cp0_addr_e pick_addr(input word_t r);
        case (r % 32'd7)
            32'd0:   return COUNT;
            32'd1:   return COMPARE;
            32'd2:   return STATUS;
            32'd3:   return CAUSE;
            32'd4:   return EPC;
            32'd5:   return PRID;
            default: return CONFIG;
        endcase
    endfunction

    // mem stage write first, then write-back, then the stored value
    function automatic word_t forward(input cp0_addr_e a, input cp0_wr_t m,
                                      input cp0_wr_t w, input word_t st);
        if (m.we && m.addr == a) begin
            return m.data;
        end
        if (w.we && w.addr == a) begin
            return w.data;
        end
        return st;
    endfunction

    function automatic logic [4:0] code_of(input exc_type_e t);
        case (t)
            EXC_SYSCALL:  return EXCCODE_SYS;
            EXC_INVALID:  return EXCCODE_RI;
            EXC_TRAP:     return EXCCODE_TR;
            EXC_OVERFLOW: return EXCCODE_OV;
            default:      return EXCCODE_INT;
        endcase
    endfunction

    always_comb begin
        case (raddr)
            COUNT:   stored = m_count;
            COMPARE: stored = m_compare;
            STATUS:  stored = m_status;
            CAUSE:   stored = m_cause;
            EPC:     stored = m_epc;
            PRID:    stored = PRID_CFG;
            CONFIG:  stored = CONFIG_VALUE;
            default: stored = '0;
        endcase
        exp_rdata  = forward(raddr, mem_wr, wb_wr, stored);
        exp_status = forward(STATUS, mem_wr, wb_wr, m_status);
        exp_cause  = forward(CAUSE, mem_wr, wb_wr, m_cause);
        int_taken  = exp_status[STATUS_IE] && !exp_status[STATUS_EXL]
                     && ((exp_status[15:8] & exp_cause[15:8]) != 8'd0);
        exp_exc = EXC_NONE;
        if (mem_exc.valid) begin
            if (int_taken) begin
                exp_exc = EXC_INT;
            end else if (mem_exc.syscall) begin
                exp_exc = EXC_SYSCALL;
            end else if (mem_exc.invalid) begin
                exp_exc = EXC_INVALID;
            end else if (mem_exc.trap) begin
                exp_exc = EXC_TRAP;
            end else if (mem_exc.overflow) begin
                exp_exc = EXC_OVERFLOW;
            end else if (mem_exc.eret) begin
                exp_exc = EXC_ERET;
            end
        end
        exp_flush  = (exp_exc != EXC_NONE);
        exp_target = (exp_exc == EXC_ERET) ? m_epc : EXC_VECTOR_CFG;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            m_status  <= STATUS_RESET;
            m_cause   <= '0;
            m_epc     <= '0;
            m_compare <= '0;
            m_count   <= '0;
            m_tint    <= 1'b0;
        end else begin
            m_count <= m_count + 32'd1;
            if (m_compare != '0 && m_compare == m_count) begin
                m_tint <= 1'b1;
            end
            if (wb_wr.we) begin
                case (wb_wr.addr)
                    COUNT:   m_count <= wb_wr.data;
                    COMPARE: begin
                        m_compare <= wb_wr.data;
                        m_tint    <= 1'b0;  // compare write acks the timer
                    end
                    STATUS:  m_status <= wb_wr.data;
                    CAUSE:   m_cause <= (m_cause & ~CAUSE_WMASK) | (wb_wr.data & CAUSE_WMASK);
                    EPC:     m_epc <= wb_wr.data;
                    default: ;
                endcase
            end
            m_cause[15:10]    <= {int_lines[5] | m_tint, int_lines[4:0]};
            m_cause[CAUSE_TI] <= m_tint;
            if (exp_exc == EXC_ERET) begin
                m_status[STATUS_EXL] <= 1'b0;
            end else if (exp_exc != EXC_NONE) begin
                m_status[STATUS_EXL] <= 1'b1;
                m_cause[6:2]         <= code_of(exp_exc);
                if (exp_exc == EXC_INT || !m_status[STATUS_EXL]) begin
                    m_epc             <= mem_exc.in_delayslot ? mem_exc.pc - 32'd4 : mem_exc.pc;
                    m_cause[CAUSE_BD] <= mem_exc.in_delayslot;
                end
            end
        end
    end

    // how often the stimulus reached the timer and exception paths
    always @(posedge clk) begin
        if (rst_n_i) begin
            if (timer_int) timer_cycles <= timer_cycles + 1;
            if (flush) flush_cycles <= flush_cycles + 1;
            if (exc_type == EXC_INT) int_cycles <= int_cycles + 1;
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic mismatch(input string what, input word_t exp, input word_t act);
        $display("ERROR test=%s %s expected=%08h actual=%08h", test_name, what, exp, act);
        $display("Finished with errors");
        $fatal(1);
    endtask

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n_i) rdata == exp_rdata)
        else mismatch("rdata_o", $sampled(exp_rdata), $sampled(rdata));
    a_status: assert property (@(posedge clk) disable iff (!rst_n_i) status_v == exp_status)
        else mismatch("status_o", $sampled(exp_status), $sampled(status_v));
    a_cause: assert property (@(posedge clk) disable iff (!rst_n_i) cause_v == exp_cause)
        else mismatch("cause_o", $sampled(exp_cause), $sampled(cause_v));
    a_timer: assert property (@(posedge clk) disable iff (!rst_n_i) timer_int == m_tint)
        else mismatch("timer_int_o", 32'($sampled(m_tint)), 32'($sampled(timer_int)));
    a_flush: assert property (@(posedge clk) disable iff (!rst_n_i) flush == exp_flush)
        else mismatch("flush_o", 32'($sampled(exp_flush)), 32'($sampled(flush)));
    a_exc_type: assert property (@(posedge clk) disable iff (!rst_n_i) exc_type == exp_exc)
        else mismatch("exc_type_o", 32'($sampled(exp_exc)), 32'($sampled(exc_type)));
    a_target: assert property (@(posedge clk) disable iff (!rst_n_i) exc_target == exp_target)
        else mismatch("exc_target_o", $sampled(exp_target), $sampled(exc_target));

    task automatic tick();
        @(posedge clk);
        #2;  // drive point after the edge
    endtask

    task automatic write_wb(input cp0_addr_e a, input word_t d);
        wb_wr.we   = 1'b1;
        wb_wr.addr = a;
        wb_wr.data = d;
        tick();
        wb_wr.we = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("watchdog expired before the tests finished");
    end

    initial begin
        word_t     d;
        word_t     flags;
        cp0_addr_e a;
        int        waited;
        rng_state = 32'd78;
        rst_n_i   = 1'b0;
        wb_wr     = '0;
        mem_wr    = '0;
        mem_exc   = '0;
        raddr     = STATUS;
        int_lines = '0;
        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        test_name = "reg_rw";
        for (int i = 0; i < 60; i++) begin
            a     = pick_addr(rand_word());
            raddr = a;
            write_wb(a, rand_word());
            repeat (2) tick();  // count keeps moving on
        end
        raddr = cp0_addr_e'(5'd3);  // unimplemented register
        tick();

        test_name = "forwarding";
        for (int i = 0; i < 40; i++) begin
            a           = pick_addr(rand_word());
            raddr       = a;
            mem_wr.we   = 1'b1;
            mem_wr.addr = a;
            mem_wr.data = rand_word();
            wb_wr.we    = 1'b1;
            wb_wr.addr  = a;
            wb_wr.data  = rand_word();
            tick();
            wb_wr.we = 1'b0;
            tick();
            mem_wr.we = 1'b0;
            wb_wr.we  = 1'b1;
            tick();
            wb_wr.we = 1'b0;
        end

        test_name = "timer";
        raddr = CAUSE;
        write_wb(COUNT, 32'd100);
        write_wb(COMPARE, 32'd130);
        waited = 0;
        while (!timer_int && waited < 100) begin
            tick();
            waited++;
        end
        if (!timer_int) fail_run("timer interrupt did not rise after the compare match");
        repeat (10) tick();
        write_wb(COMPARE, '0);
        write_wb(COUNT, '0);  // zero compare must not fire
        repeat (60) tick();

        write_wb(STATUS, STATUS_RESET);  // interrupts off
        raddr = EPC;
        for (int i = 0; i < 32; i++) begin
            test_name = "sync_exc";
            flags = rand_word();
            if (i < 8) flags[3:0] = 4'b0001 << (i % 4);
            d = rand_word();
            mem_exc              = '0;
            mem_exc.valid        = 1'b1;
            mem_exc.syscall      = flags[0];
            mem_exc.invalid      = flags[1];
            mem_exc.trap         = flags[2];
            mem_exc.overflow     = flags[3];
            mem_exc.in_delayslot = flags[8];
            mem_exc.pc           = {d[31:2], 2'b00};
            tick();
            d = rand_word();
            mem_exc.in_delayslot = flags[9];  // nested, epc stays
            mem_exc.pc           = {d[31:2], 2'b00};
            tick();
            test_name     = "eret";
            mem_exc       = '0;
            mem_exc.valid = 1'b1;
            mem_exc.eret  = 1'b1;
            tick();
            mem_exc.valid = 1'b0;
            tick();
        end

        test_name = "interrupt";
        for (int i = 0; i < 200; i++) begin
            d = rand_word();
            d[STATUS_EXL] = 1'b0;
            flags = rand_word();
            int_lines = flags[29:24];
            write_wb(STATUS, d);
            d = rand_word();
            mem_exc.valid        = flags[0];
            mem_exc.syscall      = flags[1] & flags[2];
            mem_exc.trap         = flags[3] & flags[4];
            mem_exc.eret         = flags[6] & flags[7];
            mem_exc.in_delayslot = flags[5];
            mem_exc.pc           = {d[31:2], 2'b00};
            tick();
            mem_exc = '0;
            tick();
        end
        int_lines = '0;
        tick();

        if (timer_cycles == 0 || int_cycles == 0 || flush_cycles == 0) begin
            fail_run("stimulus never reached the timer or exception checks");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// ==== design/cp0_top.sv ====
`timescale 1ns/1ps

module cp0_top
    import cp0_pkg::*;
#(
    parameter word_t PRID_VALUE = 32'h0048_0102,
    parameter word_t EXC_VECTOR = 32'hbfc0_0380
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  cp0_wr_t    wb_wr_i,
    input  cp0_wr_t    mem_wr_i,
    input  cp0_addr_e  raddr_i,
    input  logic [5:0] int_i,
    input  mem_exc_t   mem_exc_i,
    output word_t      rdata_o,
    output word_t      status_o,
    output word_t      cause_o,
    output logic       timer_int_o,
    output logic       flush_o,
    output exc_type_e  exc_type_o,
    output word_t      exc_target_o
);

    word_t     count;
    word_t     compare;
    word_t     status_q;
    word_t     cause_q;
    word_t     epc;
    word_t     config_val;
    word_t     prid_val;
    logic      timer_int;
    exc_type_e exc_type;

    cp0_timer u_timer (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_wr_i     (wb_wr_i),
        .count_o     (count),
        .compare_o   (compare),
        .timer_int_o (timer_int)
    );

    cp0_regs #(
        .PRID_VALUE (PRID_VALUE)
    ) u_regs (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_wr_i     (wb_wr_i),
        .int_i       (int_i),
        .timer_int_i (timer_int),
        .exc_type_i  (exc_type),
        .mem_exc_i   (mem_exc_i),
        .status_o    (status_q),
        .cause_o     (cause_q),
        .epc_o       (epc),
        .config_o    (config_val),
        .prid_o      (prid_val)
    );

    cp0_read_fwd u_read_fwd (
        .raddr_i       (raddr_i),
        .mem_wr_i      (mem_wr_i),
        .wb_wr_i       (wb_wr_i),
        .count_i       (count),
        .compare_i     (compare),
        .status_i      (status_q),
        .cause_i       (cause_q),
        .epc_i         (epc),
        .config_i      (config_val),
        .prid_i        (prid_val),
        .rdata_o       (rdata_o),
        .status_view_o (status_o),  // forwarded views feed the arbiter too
        .cause_view_o  (cause_o)
    );

    cp0_exc_arbiter #(
        .EXC_VECTOR (EXC_VECTOR)
    ) u_exc_arbiter (
        .mem_exc_i    (mem_exc_i),
        .status_i     (status_o),
        .cause_i      (cause_o),
        .epc_i        (epc),
        .exc_type_o   (exc_type),
        .flush_o      (flush_o),
        .exc_target_o (exc_target_o)
    );

    assign timer_int_o = timer_int;
    assign exc_type_o  = exc_type;

endmodule

// ==== design/cp0_exc_arbiter.sv ====
`timescale 1ns/1ps

module cp0_exc_arbiter
    import cp0_pkg::*;
#(
    parameter word_t EXC_VECTOR = 32'hbfc0_0380
) (
    input  mem_exc_t  mem_exc_i,
    input  word_t     status_i,
    input  word_t     cause_i,
    input  word_t     epc_i,
    output exc_type_e exc_type_o,
    output logic      flush_o,
    output word_t     exc_target_o
);

    logic [7:0] im;
    logic [7:0] ip;
    logic       int_pending;
    exc_type_e  exc_type;

    assign im = status_i[STATUS_IM_HI:STATUS_IM_LO];
    assign ip = cause_i[CAUSE_IP_HW_HI:CAUSE_IP_SW_LO];  // hw and sw pending bits

    assign int_pending = status_i[STATUS_IE] && !status_i[STATUS_EXL] && |(im & ip);

    always_comb begin
        exc_type = EXC_NONE;
        if (mem_exc_i.valid) begin
            if (int_pending) begin
                exc_type = EXC_INT;  // interrupt taken ahead of any sync fault
            end else if (mem_exc_i.syscall) begin
                exc_type = EXC_SYSCALL;
            end else if (mem_exc_i.invalid) begin
                exc_type = EXC_INVALID;
            end else if (mem_exc_i.trap) begin
                exc_type = EXC_TRAP;
            end else if (mem_exc_i.overflow) begin
                exc_type = EXC_OVERFLOW;
            end else if (mem_exc_i.eret) begin
                exc_type = EXC_ERET;
            end
        end
    end

    assign exc_type_o   = exc_type;
    assign flush_o      = (exc_type != EXC_NONE);
    assign exc_target_o = (exc_type == EXC_ERET) ? epc_i : EXC_VECTOR;

    // no clock here, checked whenever the inputs settle
    always_comb begin
        if (flush_o) begin
            a_flush_needs_valid: assert (mem_exc_i.valid)
                else $error("flush without a valid mem stage instruction");
        end
    end

endmodule

// ==== design/cp0_read_fwd.sv ====
`timescale 1ns/1ps

module cp0_read_fwd
    import cp0_pkg::*;
(
    input  cp0_addr_e raddr_i,
    input  cp0_wr_t   mem_wr_i,
    input  cp0_wr_t   wb_wr_i,
    input  word_t     count_i,
    input  word_t     compare_i,
    input  word_t     status_i,
    input  word_t     cause_i,
    input  word_t     epc_i,
    input  word_t     config_i,
    input  word_t     prid_i,
    output word_t     rdata_o,
    output word_t     status_view_o,
    output word_t     cause_view_o
);

    word_t stored_rdata;

    // younger instruction (mem) wins over write-back
    function automatic word_t fwd(input cp0_addr_e a, input cp0_wr_t m,
                                  input cp0_wr_t w, input word_t stored);
        if (m.we && m.addr == a) begin
            return m.data;
        end
        if (w.we && w.addr == a) begin
            return w.data;
        end
        return stored;
    endfunction

    always_comb begin
        case (raddr_i)
            COUNT:   stored_rdata = count_i;
            COMPARE: stored_rdata = compare_i;
            STATUS:  stored_rdata = status_i;
            CAUSE:   stored_rdata = cause_i;
            EPC:     stored_rdata = epc_i;
            CONFIG:  stored_rdata = config_i;
            PRID:    stored_rdata = prid_i;
            default: stored_rdata = '0;  // unimplemented regs read zero
        endcase
    end

    assign rdata_o = fwd(raddr_i, mem_wr_i, wb_wr_i, stored_rdata);

    // views used by the exception logic, independent of the read port
    assign status_view_o = fwd(STATUS, mem_wr_i, wb_wr_i, status_i);
    assign cause_view_o  = fwd(CAUSE, mem_wr_i, wb_wr_i, cause_i);

endmodule

// ==== design/cp0_regs.sv ====
`timescale 1ns/1ps

module cp0_regs
    import cp0_pkg::*;
#(
    parameter word_t PRID_VALUE = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst_n_i,
    input  cp0_wr_t   wb_wr_i,
    input  logic [5:0] int_i,
    input  logic      timer_int_i,
    input  exc_type_e exc_type_i,
    input  mem_exc_t  mem_exc_i,
    output word_t     status_o,
    output word_t     cause_o,
    output word_t     epc_o,
    output word_t     config_o,
    output word_t     prid_o
);

    word_t      status_q;
    word_t      cause_q;
    word_t      epc_q;
    logic [4:0] exc_code;
    logic       commit;
    logic       save_epc;
    word_t      epc_next;

    always_comb begin
        case (exc_type_i)
            EXC_INT:      exc_code = EXCCODE_INT;
            EXC_SYSCALL:  exc_code = EXCCODE_SYS;
            EXC_INVALID:  exc_code = EXCCODE_RI;
            EXC_TRAP:     exc_code = EXCCODE_TR;
            EXC_OVERFLOW: exc_code = EXCCODE_OV;
            default:      exc_code = EXCCODE_INT;
        endcase
    end

    assign commit = (exc_type_i != EXC_NONE) && (exc_type_i != EXC_ERET);

    // only interrupts overwrite the epc of a nested exception
    assign save_epc = (exc_type_i == EXC_INT) || !status_q[STATUS_EXL];

    // a delay slot restarts at the branch
    assign epc_next = mem_exc_i.in_delayslot ? mem_exc_i.pc - 32'd4 : mem_exc_i.pc;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            status_q <= STATUS_RESET;
            cause_q  <= '0;
            epc_q    <= '0;
        end else begin
            if (wb_wr_i.we) begin
                case (wb_wr_i.addr)
                    STATUS: status_q <= wb_wr_i.data;
                    CAUSE:  cause_q  <= (cause_q & ~CAUSE_WMASK) | (wb_wr_i.data & CAUSE_WMASK);
                    EPC:    epc_q    <= wb_wr_i.data;
                    default: ;
                endcase
            end

            // hardware lines sampled every cycle on top of the masked write
            cause_q[CAUSE_IP_HW_HI:CAUSE_IP_HW_LO] <= {int_i[5] | timer_int_i, int_i[4:0]};
            cause_q[CAUSE_TI] <= timer_int_i;

            // commit comes last so it overrides a same-cycle mtc0
            if (exc_type_i == EXC_ERET) begin
                status_q[STATUS_EXL] <= 1'b0;
            end else if (commit) begin
                status_q[STATUS_EXL] <= 1'b1;
                cause_q[CAUSE_EXC_HI:CAUSE_EXC_LO] <= exc_code;
                if (save_epc) begin
                    epc_q             <= epc_next;
                    cause_q[CAUSE_BD] <= mem_exc_i.in_delayslot;
                end
            end
        end
    end

    assign status_o = status_q;
    assign cause_o  = cause_q;
    assign epc_o    = epc_q;
    assign config_o = CONFIG_VALUE;  // read only
    assign prid_o   = PRID_VALUE;

    a_exccode_only_on_commit: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$stable(cause_q[CAUSE_EXC_HI:CAUSE_EXC_LO]) |-> $past(commit));

endmodule

// ==== design/cp0_timer.sv ====
`timescale 1ns/1ps

module cp0_timer
    import cp0_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  cp0_wr_t wb_wr_i,
    output word_t   count_o,
    output word_t   compare_o,
    output logic    timer_int_o
);

    word_t count_q;
    word_t compare_q;
    logic  timer_int_q;
    logic  timer_match;

    assign timer_match = (compare_q != '0) && (compare_q == count_q);  // zero compare disables

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count_q     <= '0;
            compare_q   <= '0;
            timer_int_q <= 1'b0;
        end else begin
            count_q <= count_q + 32'd1;  // free running
            if (timer_match) begin
                timer_int_q <= 1'b1;  // sticky
            end
            if (wb_wr_i.we) begin
                case (wb_wr_i.addr)
                    COUNT: count_q <= wb_wr_i.data;
                    COMPARE: begin
                        compare_q   <= wb_wr_i.data;
                        timer_int_q <= 1'b0;  // ack wins over a match
                    end
                    default: ;
                endcase
            end
        end
    end

    assign count_o     = count_q;
    assign compare_o   = compare_q;
    assign timer_int_o = timer_int_q;

    a_cmp_write_clears: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wb_wr_i.we && wb_wr_i.addr == COMPARE) |=> !timer_int_o);

endmodule

// ==== design/cp0_pkg.sv ====
package cp0_pkg;

    typedef logic [31:0] word_t;

    // cp0 register numbers, select 0 only
    typedef enum logic [4:0] {
        COUNT   = 5'd9,
        COMPARE = 5'd11,
        STATUS  = 5'd12,
        CAUSE   = 5'd13,
        EPC     = 5'd14,
        PRID    = 5'd15,
        CONFIG  = 5'd16
    } cp0_addr_e;

    // final exception picked for the mem stage instruction
    typedef enum logic [2:0] {
        EXC_NONE     = 3'd0,
        EXC_INT      = 3'd1,
        EXC_SYSCALL  = 3'd2,
        EXC_INVALID  = 3'd3,
        EXC_TRAP     = 3'd4,
        EXC_OVERFLOW = 3'd5,
        EXC_ERET     = 3'd6
    } exc_type_e;

    localparam logic [4:0] EXCCODE_INT = 5'd0;
    localparam logic [4:0] EXCCODE_SYS = 5'd8;
    localparam logic [4:0] EXCCODE_RI  = 5'd10;
    localparam logic [4:0] EXCCODE_OV  = 5'd12;
    localparam logic [4:0] EXCCODE_TR  = 5'd13;

    localparam int STATUS_IE     = 0;
    localparam int STATUS_EXL    = 1;
    localparam int STATUS_IM_HI  = 15;
    localparam int STATUS_IM_LO  = 8;

    localparam int CAUSE_BD       = 31;
    localparam int CAUSE_TI       = 30;
    localparam int CAUSE_IV       = 23;
    localparam int CAUSE_WP       = 22;
    localparam int CAUSE_IP_HW_HI = 15;
    localparam int CAUSE_IP_HW_LO = 10;
    localparam int CAUSE_IP_SW_HI = 9;
    localparam int CAUSE_IP_SW_LO = 8;
    localparam int CAUSE_EXC_HI   = 6;
    localparam int CAUSE_EXC_LO   = 2;

    localparam word_t CAUSE_WMASK  = 32'h00c0_0300;  // iv, wp, ip[1:0]
    localparam word_t STATUS_RESET = 32'h1000_0000;  // cu0 set
    localparam word_t CONFIG_VALUE = 32'h0000_8000;  // big endian, no mmu

    typedef struct packed {
        logic      we;
        cp0_addr_e addr;
        word_t     data;
    } cp0_wr_t;

    typedef struct packed {
        logic  valid;
        logic  syscall;
        logic  invalid;
        logic  trap;
        logic  overflow;
        logic  eret;
        logic  in_delayslot;
        word_t pc;
    } mem_exc_t;

endpackage
